// File: Makefile
TOP := tb_noncomp_fmt_slice

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): all.f hw/*.sv hw/*.svh bench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+hw
hw/fpslice_pkg.sv
hw/fp_classifier.sv
hw/noncomp_lane.sv
hw/slice_collect.sv
hw/noncomp_fmt_slice.sv
bench/noncomp_fmt_slice_properties.sv
bench/tb_noncomp_fmt_slice.sv

// File: bench/noncomp_fmt_slice_properties.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module noncomp_fmt_slice_properties (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    flush_i,
  input logic                    in_ready_o,
  input logic                    out_valid_o,
  input logic                    out_ready_i,
  input logic                    busy_o,
  input logic [`SLICE_WIDTH-1:0] result_o
);

  // Output register empties under reset
  a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  // ----------------------------------------
  // Back-pressure
  // ----------------------------------------
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o))
    else $error("stalled output changed or dropped");

  a_stall_blocks_input: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |-> !in_ready_o)
    else $error("in_ready_o high while the output is stalled");

  a_busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> busy_o)
    else $error("busy_o low while out_valid_o is high");

endmodule

bind noncomp_fmt_slice noncomp_fmt_slice_properties u_properties (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .result_o    (result_o)
);

// File: bench/tb_noncomp_fmt_slice.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module tb_noncomp_fmt_slice import fpslice_pkg::*; ();

  localparam int NUM_OPS     = 43;  // Requests issued over all tests
  localparam int WAIT_CYCLES = 50;
  localparam logic [15:0] CLASS_VALS [10] = '{
    16'hFC00, 16'hBC00, 16'h8001, 16'h8000, 16'h0000,
    16'h0200, 16'h3C00, 16'h7C00, 16'h7C01, 16'h7E00
  };  // One value per class in mask bit order

  logic                                       clk;
  logic                                       rst_n;
  logic [`NUM_OPERANDS-1:0][`SLICE_WIDTH-1:0] operands;
  roundmode_e                                 rnd_mode;
  op_e                                        op;
  logic                                       op_mod;
  logic                                       vectorial;
  logic [`TAG_WIDTH-1:0]                      tag;
  logic [`NUM_LANES-1:0]                      simd_mask;
  logic                                       in_valid;
  logic                                       in_ready;
  logic                                       flush;
  logic [`SLICE_WIDTH-1:0]                    result;
  status_t                                    status;
  logic                                       ext_bit;
  logic [`TAG_WIDTH-1:0]                      tag_out;
  logic                                       out_valid;
  logic                                       out_ready;
  logic                                       busy;

  noncomp_fmt_slice u_noncomp_fmt_slice (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .operands_i      (operands),
    .rnd_mode_i      (rnd_mode),
    .op_i            (op),
    .op_mod_i        (op_mod),
    .vectorial_op_i  (vectorial),
    .tag_i           (tag),
    .simd_mask_i     (simd_mask),
    .in_valid_i      (in_valid),
    .in_ready_o      (in_ready),
    .flush_i         (flush),
    .result_o        (result),
    .status_o        (status),
    .extension_bit_o (ext_bit),
    .tag_o           (tag_out),
    .out_valid_o     (out_valid),
    .out_ready_i     (out_ready),
    .busy_o          (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic is_nan16(input logic [15:0] v);
    return (v[14:10] == 5'h1F) && (v[9:0] != 10'h0);
  endfunction

  function automatic logic is_snan16(input logic [15:0] v);
    return is_nan16(v) && !v[9];
  endfunction

  // Maps sign-magnitude onto an unsigned order with -0 just below +0
  function automatic logic [15:0] order_key(input logic [15:0] v);
    return v[15] ? ~v : (v | 16'h8000);
  endfunction

  function automatic logic [15:0] sgnj_model(input roundmode_e rm, input logic [15:0] a,
                                             input logic [15:0] b);
    logic s;
    case (rm)
      RNE:     s = b[15];
      RTZ:     s = ~b[15];
      default: s = a[15] ^ b[15];
    endcase
    return {s, a[14:0]};
  endfunction

  function automatic logic [15:0] minmax_model(input roundmode_e rm, input logic [15:0] a,
                                               input logic [15:0] b);
    logic [15:0] lo;
    logic [15:0] hi;
    if (is_nan16(a) && is_nan16(b)) return `CANON_NAN;
    if (is_nan16(a)) return b;
    if (is_nan16(b)) return a;
    if (order_key(a) <= order_key(b)) begin
      lo = a;
      hi = b;
    end else begin
      lo = b;
      hi = a;
    end
    return (rm == RTZ) ? hi : lo;
  endfunction

  function automatic classmask_e class_model(input logic [15:0] v);
    logic [4:0] e;
    logic [9:0] m;
    e = v[14:10];
    m = v[9:0];
    if (e == 5'h1F) begin
      if (m == 10'h0) return v[15] ? NEGINF : POSINF;
      return m[9] ? QNAN : SNAN;
    end
    if (e != 5'h0) return v[15] ? NEGNORM : POSNORM;
    if (m != 10'h0) return v[15] ? NEGSUBNORM : POSSUBNORM;
    return v[15] ? NEGZERO : POSZERO;
  endfunction

  function automatic logic [7:0] block_model(input logic [15:0] v);
    logic [7:0] blk;
    blk = 8'h00;
    case (class_model(v))
      NEGINF, POSINF:         blk[0] = 1'b1;
      NEGNORM, POSNORM:       blk[1] = 1'b1;
      NEGSUBNORM, POSSUBNORM: blk[2] = 1'b1;
      NEGZERO, POSZERO:       blk[3] = 1'b1;
      SNAN:                   blk[4] = 1'b1;
      default:                blk[5] = 1'b1;
    endcase
    if (v[15] && !is_nan16(v)) blk[7] = 1'b1;
    else blk[6] = 1'b1;  // NaNs count as not negative
    return blk;
  endfunction

  // ----------------------------------------
  // Checking and driving
  // ----------------------------------------
  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_error(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic compare_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic compare_tag(input string name, input logic [`TAG_WIDTH-1:0] got,
                             input logic [`TAG_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic drive_fields(input op_e o, input roundmode_e rm, input logic vec,
                              input logic [3:0] msk, input logic [63:0] a,
                              input logic [63:0] b, input logic [3:0] t);
    op          = o;
    rnd_mode    = rm;
    vectorial   = vec;
    simd_mask   = msk;
    operands[0] = a;
    operands[1] = b;
    tag         = t;
  endtask

  // Holds the request until the DUT takes it
  task automatic send_req(input op_e o, input roundmode_e rm, input logic vec,
                          input logic [3:0] msk, input logic [63:0] a,
                          input logic [63:0] b, input logic [3:0] t);
    int waited;
    waited = 0;
    drive_fields(o, rm, vec, msk, a, b, t);
    in_valid = 1'b1;
    while (!in_ready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_CYCLES) report_error("in_ready_o never rose for a pending request");
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_output();
    int waited;
    waited = 0;
    while (!out_valid) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_CYCLES) report_error("out_valid_o did not rise after a request");
    end
  endtask

  task automatic run_op(input op_e o, input roundmode_e rm, input logic vec,
                        input logic [3:0] msk, input logic [63:0] a, input logic [63:0] b,
                        input logic [63:0] exp_res, input status_t exp_st, input logic exp_ext);
    logic [3:0] t;
    t = 4'($urandom);
    send_req(o, rm, vec, msk, a, b, t);
    wait_output();
    compare_word("result_o", result, exp_res);
    compare_status("status_o", status, exp_st);
    compare_tag("tag_o", tag_out, t);
    compare_word("extension_bit_o", {63'b0, ext_bit}, {63'b0, exp_ext});
    @(posedge clk);  // Output taken here
    #1;
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_sgnj_scalar();
    roundmode_e  modes [3] = '{RNE, RTZ, RDN};
    logic [63:0] a;
    logic [63:0] b;
    for (int r = 0; r < 3; r++) begin
      for (int n = 0; n < 4; n++) begin
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        run_op(SGNJ, modes[r], 1'b0, 4'b0001, a, b,
               {48'hFFFF_FFFF_FFFF, sgnj_model(modes[r], a[15:0], b[15:0])}, '0, 1'b1);
      end
    end
  endtask

  task automatic check_minmax(input roundmode_e rm, input logic [3:0] msk,
                              input logic [63:0] a, input logic [63:0] b);
    logic [63:0] exp_res;
    status_t     exp_st;
    exp_st = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      exp_res[i*16 +: 16] = minmax_model(rm, a[i*16 +: 16], b[i*16 +: 16]);
      if (msk[i] && (is_snan16(a[i*16 +: 16]) || is_snan16(b[i*16 +: 16]))) exp_st.nv = 1'b1;
    end
    run_op(MINMAX, rm, 1'b1, msk, a, b, exp_res, exp_st, 1'b1);
  endtask

  task automatic test_minmax_vector();
    logic [63:0] a;
    logic [63:0] b;
    // qNaN vs 1.0, -0 vs +0, sNaN vs 2.0, two NaNs
    a = {16'hFE00, 16'h7C01, 16'h8000, 16'h7E00};
    b = {16'h7C10, 16'h4000, 16'h0000, 16'h3C00};
    for (int k = 0; k < 2; k++) begin
      check_minmax(k ? RTZ : RNE, 4'b1111, a, b);
      check_minmax(k ? RTZ : RNE, 4'b0011, a, b);  // sNaN lanes masked out
      check_minmax(k ? RTZ : RNE, 4'b0100, a, b);
    end
    for (int n = 0; n < 2; n++) begin
      check_minmax(n ? RTZ : RNE, 4'b1111, {$urandom, $urandom}, {$urandom, $urandom});
    end
  endtask

  task automatic test_classify();
    logic [63:0] a;
    logic [63:0] exp_res;
    for (int i = 0; i < 10; i++) begin
      a = {$urandom, $urandom};
      a[15:0] = CLASS_VALS[i];
      run_op(CLASSIFY, RNE, 1'b0, 4'b0001, a, 64'h0, 64'd1 << i, '0, 1'b0);
    end
    for (int g = 0; g < 3; g++) begin
      exp_res = 64'h0;
      for (int i = 0; i < `NUM_LANES; i++) begin
        a[i*16 +: 16]      = CLASS_VALS[(g*4 + i) % 10];
        exp_res[i*8 +: 8] = block_model(a[i*16 +: 16]);
      end
      run_op(CLASSIFY, RNE, 1'b1, 4'b1111, a, 64'h0, exp_res, '0, 1'b0);
    end
  endtask

  task automatic test_backpressure();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_res;
    logic [3:0]  t;
    a       = {$urandom, $urandom};
    b       = {$urandom, $urandom};
    t       = 4'($urandom);
    exp_res = {48'hFFFF_FFFF_FFFF, sgnj_model(RTZ, a[15:0], b[15:0])};
    out_ready = 1'b0;
    send_req(SGNJ, RTZ, 1'b0, 4'b0001, a, b, t);
    wait_output();
    repeat (5) begin
      if (!out_valid) report_error("out_valid_o dropped while the output was stalled");
      if (in_ready) report_error("in_ready_o high while the output was stalled");
      compare_word("result_o", result, exp_res);
      compare_tag("tag_o", tag_out, t);
      @(posedge clk);
      #1;
    end
    out_ready = 1'b1;
    @(posedge clk);
    #1;
    if (out_valid) report_error("stalled result was not taken exactly once");
  endtask

  task automatic test_throughput();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp_res;
    logic [3:0]  t;
    logic [63:0] exp_q [$];
    logic [3:0]  tag_q [$];
    out_ready = 1'b1;
    for (int i = 0; i <= 8; i++) begin
      if (i > 0) begin
        if (!out_valid) report_error("no result one cycle after acceptance");
        compare_word("result_o", result, exp_q.pop_front());
        compare_tag("tag_o", tag_out, tag_q.pop_front());
      end
      if (i < 8) begin
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        t = 4'($urandom);
        for (int l = 0; l < `NUM_LANES; l++) begin
          exp_res[l*16 +: 16] = sgnj_model(i[0] ? RDN : RNE, a[l*16 +: 16], b[l*16 +: 16]);
        end
        exp_q.push_back(exp_res);
        tag_q.push_back(t);
        drive_fields(SGNJ, i[0] ? RDN : RNE, 1'b1, 4'b1111, a, b, t);
        in_valid = 1'b1;
        if (!in_ready) report_error("in_ready_o low during back-to-back issue");
      end else begin
        in_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic test_flush();
    out_ready = 1'b0;
    send_req(MINMAX, RNE, 1'b1, 4'b1111, {$urandom, $urandom}, {$urandom, $urandom}, 4'hA);
    wait_output();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    if (out_valid) report_error("out_valid_o still high after flush");
    if (busy) report_error("busy_o still high after flush");
    out_ready = 1'b1;
  endtask

  // Watchdog
  initial begin
    repeat (NUM_OPS * WAIT_CYCLES + 10) @(posedge clk);
    report_error("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(46385));
    rst_n     = 1'b0;
    operands  = '0;
    rnd_mode  = RNE;
    op        = SGNJ;
    op_mod    = 1'b0;
    vectorial = 1'b0;
    tag       = '0;
    simd_mask = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (out_valid || busy || !in_ready) report_error("wrong handshake state after reset");
    test_sgnj_scalar();
    test_minmax_vector();
    test_classify();
    test_backpressure();
    test_throughput();
    test_flush();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: hw/fp_classifier.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module fp_classifier import fpslice_pkg::*; (
  input  fp16_u      value_i,
  output classmask_e class_o,
  output logic       is_nan_o,
  output logic       is_snan_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;
  logic sign;

  // Field decode
  assign sign     = value_i.fields.sign;
  assign exp_zero = (value_i.fields.exponent == '0);
  assign exp_ones = &value_i.fields.exponent;
  assign man_zero = (value_i.fields.mantissa == '0);

  assign is_nan_o  = exp_ones & ~man_zero;
  // Quiet bit is the mantissa MSB
  assign is_snan_o = is_nan_o & ~value_i.fields.mantissa[`MAN_WIDTH-1];

  // ----------------------------------------
  // Exactly one class per value
  // ----------------------------------------
  always_comb begin : classify
    if (is_nan_o) begin
      class_o = is_snan_o ? SNAN : QNAN;  // Sign ignored for NaNs
    end else if (exp_ones) begin
      class_o = sign ? NEGINF : POSINF;
    end else if (exp_zero && man_zero) begin
      class_o = sign ? NEGZERO : POSZERO;
    end else if (exp_zero) begin
      class_o = sign ? NEGSUBNORM : POSSUBNORM;
    end else begin
      class_o = sign ? NEGNORM : POSNORM;
    end
  end

endmodule

// File: hw/fpslice_pkg.sv
`include "fpslice_settings.svh"

package fpslice_pkg;

  // ----------------------------------------
  // Operation select
  // ----------------------------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CLASSIFY = 2'd2
  } op_e;

  // Rounding mode field, reused as the operation variant
  typedef enum logic [2:0] {
    RNE = 3'b000,  // SGNJ: inject, MINMAX: min
    RTZ = 3'b001,  // SGNJ: negated inject, MINMAX: max
    RDN = 3'b010,  // SGNJ: XOR inject
    RUP = 3'b011,
    RMM = 3'b100,
    DYN = 3'b111
  } roundmode_e;

  // One-hot class of a single value
  typedef enum logic [`NUM_CLASSES-1:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // IEEE exception flags
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // ----------------------------------------
  // FP16 views
  // ----------------------------------------
  typedef struct packed {
    logic                  sign;
    logic [`EXP_WIDTH-1:0] exponent;
    logic [`MAN_WIDTH-1:0] mantissa;
  } fp16_fields_t;

  typedef union packed {
    logic [`FP_WIDTH-1:0] raw;
    fp16_fields_t         fields;
  } fp16_u;

  // ----------------------------------------
  // Lane transport
  // ----------------------------------------
  typedef struct packed {
    logic [`NUM_OPERANDS-1:0][`FP_WIDTH-1:0] operands;
    op_e                                     op;
    roundmode_e                              rnd_mode;
    logic                                    op_mod;
    logic                                    mask;       // SIMD mask bit of this lane
    logic                                    vectorial;
    logic [`TAG_WIDTH-1:0]                   tag;
  } lane_req_t;

  typedef struct packed {
    logic [`FP_WIDTH-1:0]  result;
    status_t               status;
    logic                  ext_bit;
    classmask_e            class_mask;
    logic                  is_class;
    logic                  mask;
    logic                  vectorial;
    logic [`TAG_WIDTH-1:0] tag;
  } lane_rsp_t;

endpackage

// File: hw/fpslice_settings.svh
`ifndef FPSLICE_SETTINGS_SVH
`define FPSLICE_SETTINGS_SVH

// Slice geometry
`define SLICE_WIDTH   64
`define FP_WIDTH      16
`define NUM_LANES     4
`define NUM_OPERANDS  2

// FP16 field widths
`define EXP_WIDTH     5
`define MAN_WIDTH     10

// Sideband
`define TAG_WIDTH     4

// Classification
`define NUM_CLASSES   10
`define CLASS_BLOCK   8   // Bits per lane in a vectorial classify

// Canonical quiet NaN for FP16
`define CANON_NAN     16'h7E00

`endif

// File: hw/noncomp_fmt_slice.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module noncomp_fmt_slice import fpslice_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic [`NUM_OPERANDS-1:0][`SLICE_WIDTH-1:0] operands_i,
  input  roundmode_e                                rnd_mode_i,
  input  op_e                                       op_i,
  input  logic                                      op_mod_i,
  input  logic                                      vectorial_op_i,
  input  logic [`TAG_WIDTH-1:0]                     tag_i,
  input  logic [`NUM_LANES-1:0]                     simd_mask_i,
  input  logic                                      in_valid_i,
  output logic                                      in_ready_o,
  input  logic                                      flush_i,
  output logic [`SLICE_WIDTH-1:0]                   result_o,
  output status_t                                   status_o,
  output logic                                      extension_bit_o,
  output logic [`TAG_WIDTH-1:0]                     tag_o,
  output logic                                      out_valid_o,
  input  logic                                      out_ready_i,
  output logic                                      busy_o
);

  lane_req_t [`NUM_LANES-1:0] lane_req;
  lane_rsp_t [`NUM_LANES-1:0] lane_rsp;
  logic      [`NUM_LANES-1:0] lane_in_valid;
  logic      [`NUM_LANES-1:0] lane_in_ready;
  logic      [`NUM_LANES-1:0] lane_out_valid;
  logic      [`NUM_LANES-1:0] lane_out_ready;
  logic      [`NUM_LANES-1:0] lane_valid;  // Valid as seen by the collector
  logic      [`NUM_LANES-1:0] lane_busy;
  logic                       result_is_vector;

  assign result_is_vector = lane_rsp[0].vectorial;

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : g_lane
    always_comb begin : build_req
      for (int i = 0; i < `NUM_OPERANDS; i++) begin
        lane_req[lane].operands[i] = operands_i[i][lane*`FP_WIDTH +: `FP_WIDTH];
      end
      lane_req[lane].op        = op_i;
      lane_req[lane].rnd_mode  = rnd_mode_i;
      lane_req[lane].op_mod    = op_mod_i;
      lane_req[lane].mask      = simd_mask_i[lane];
      lane_req[lane].vectorial = vectorial_op_i;
      lane_req[lane].tag       = tag_i;
    end

    // Upper lanes only take part in vectorial operations
    assign lane_in_valid[lane]  = in_valid_i & ((lane == 0) | vectorial_op_i);
    assign lane_out_ready[lane] = out_ready_i & ((lane == 0) | result_is_vector);
    assign lane_valid[lane]     = lane_out_valid[lane] & ((lane == 0) | result_is_vector);

    noncomp_lane u_lane (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush_i),
      .req_i       (lane_req[lane]),
      .in_valid_i  (lane_in_valid[lane]),
      .in_ready_o  (lane_in_ready[lane]),
      .rsp_o       (lane_rsp[lane]),
      .out_valid_o (lane_out_valid[lane]),
      .out_ready_i (lane_out_ready[lane]),
      .busy_o      (lane_busy[lane])
    );
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  slice_collect u_collect (
    .rsp_i           (lane_rsp),
    .lane_valid_i    (lane_valid),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .tag_o           (tag_o)
  );

  assign in_ready_o  = lane_in_ready[0];   // Lanes move in lock step
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

// File: hw/noncomp_lane.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module noncomp_lane import fpslice_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  lane_req_t req_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output lane_rsp_t rsp_o,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output logic      busy_o
);

  fp16_u                op_a;
  fp16_u                op_b;
  classmask_e           class_a;
  logic                 nan_a;
  logic                 nan_b;
  logic                 snan_a;
  logic                 snan_b;
  logic                 sgnj_sign;
  logic [`FP_WIDTH-1:0] sgnj_result;
  logic                 a_lt_b;
  logic                 pick_a;
  logic [`FP_WIDTH-1:0] minmax_result;
  lane_rsp_t            rsp_d;
  lane_rsp_t            rsp_q;
  logic                 valid_q;
  logic                 load;

  assign op_a.raw = req_i.operands[0];
  assign op_b.raw = req_i.operands[1];

  fp_classifier u_class_a (
    .value_i   (op_a),
    .class_o   (class_a),
    .is_nan_o  (nan_a),
    .is_snan_o (snan_a)
  );

  // Only the NaN kinds of b matter
  fp_classifier u_class_b (
    .value_i   (op_b),
    .class_o   (),
    .is_nan_o  (nan_b),
    .is_snan_o (snan_b)
  );

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  always_comb begin : sign_injection
    unique case (req_i.rnd_mode)
      RNE:     sgnj_sign = op_b.raw[`FP_WIDTH-1];                        // J
      RTZ:     sgnj_sign = ~op_b.raw[`FP_WIDTH-1];                       // JN
      RDN:     sgnj_sign = op_a.raw[`FP_WIDTH-1] ^ op_b.raw[`FP_WIDTH-1]; // JX
      default: sgnj_sign = op_a.raw[`FP_WIDTH-1];                        // Plain move
    endcase
  end

  assign sgnj_result = {sgnj_sign, op_a.raw[`FP_WIDTH-2:0]};

  // ----------------------------------------
  // Min / max
  // ----------------------------------------
  // Sign-magnitude ordering, -0 below +0
  always_comb begin : order
    if (op_a.raw[`FP_WIDTH-1] != op_b.raw[`FP_WIDTH-1]) begin
      a_lt_b = op_a.raw[`FP_WIDTH-1];
    end else if (op_a.raw[`FP_WIDTH-1]) begin
      a_lt_b = op_a.raw[`FP_WIDTH-2:0] > op_b.raw[`FP_WIDTH-2:0];
    end else begin
      a_lt_b = op_a.raw[`FP_WIDTH-2:0] < op_b.raw[`FP_WIDTH-2:0];
    end
  end

  assign pick_a = (req_i.rnd_mode == RTZ) ? ~a_lt_b : a_lt_b;  // RTZ selects max

  always_comb begin : min_max
    if (nan_a && nan_b) begin
      minmax_result = `CANON_NAN;
    end else if (nan_a) begin
      minmax_result = op_b.raw;
    end else if (nan_b) begin
      minmax_result = op_a.raw;
    end else begin
      minmax_result = pick_a ? op_a.raw : op_b.raw;
    end
  end

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  always_comb begin : select_result
    rsp_d            = '0;
    rsp_d.class_mask = class_a;
    rsp_d.mask       = req_i.mask;
    rsp_d.vectorial  = req_i.vectorial;
    rsp_d.tag        = req_i.tag;
    unique case (req_i.op)
      SGNJ: begin
        rsp_d.result  = sgnj_result;
        // op_mod turns NaN boxing into sign extension
        rsp_d.ext_bit = req_i.op_mod ? sgnj_sign : 1'b1;
      end
      MINMAX: begin
        rsp_d.result    = minmax_result;
        rsp_d.status.nv = snan_a | snan_b;
        rsp_d.ext_bit   = 1'b1;
      end
      CLASSIFY: begin
        rsp_d.is_class = 1'b1;
        rsp_d.ext_bit  = 1'b0;
      end
      default: begin
        rsp_d.ext_bit = 1'b1;
      end
    endcase
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  assign in_ready_o = ~valid_q | out_ready_i;  // Empty or draining
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign out_valid_o = valid_q;
  assign busy_o      = valid_q;

endmodule

// File: hw/slice_collect.sv
`timescale 1ns/100ps
`include "fpslice_settings.svh"

module slice_collect import fpslice_pkg::*; (
  input  lane_rsp_t [`NUM_LANES-1:0]   rsp_i,
  input  logic      [`NUM_LANES-1:0]   lane_valid_i,
  output logic      [`SLICE_WIDTH-1:0] result_o,
  output status_t                      status_o,
  output logic                         extension_bit_o,
  output logic      [`TAG_WIDTH-1:0]   tag_o
);

  localparam int unsigned CLASS_BITS = `NUM_LANES * `CLASS_BLOCK;

  logic [`SLICE_WIDTH-1:0] regular_result;
  logic [`SLICE_WIDTH-1:0] class_result;
  logic [`SLICE_WIDTH-1:0] vec_class_result;
  logic [CLASS_BITS-1:0]   class_blocks;

  // ----------------------------------------
  // Per-lane fields
  // ----------------------------------------
  for (genvar lane = 0; lane < `NUM_LANES; lane++) begin : g_lane
    classmask_e cls;
    logic       neg;

    assign cls = rsp_i[lane].class_mask;
    assign neg = cls inside {NEGINF, NEGNORM, NEGSUBNORM, NEGZERO};

    // Idle lanes are NaN-boxed from lane 0
    assign regular_result[lane*`FP_WIDTH +: `FP_WIDTH] =
        lane_valid_i[lane] ? rsp_i[lane].result : {`FP_WIDTH{rsp_i[0].ext_bit}};

    assign class_blocks[lane*`CLASS_BLOCK +: `CLASS_BLOCK] = {
      neg,                                   // 7
      ~neg,                                  // 6
      cls == QNAN,                           // 5
      cls == SNAN,                           // 4
      (cls == POSZERO) || (cls == NEGZERO),  // 3
      (cls == POSSUBNORM) || (cls == NEGSUBNORM),
      (cls == POSNORM) || (cls == NEGNORM),
      (cls == POSINF) || (cls == NEGINF)     // 0
    };
  end

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  assign vec_class_result = {{(`SLICE_WIDTH - CLASS_BITS){1'b0}}, class_blocks};

  // Scalar classify keeps the full one-hot mask
  assign class_result = rsp_i[0].vectorial ? vec_class_result
                      : {{(`SLICE_WIDTH - `NUM_CLASSES){1'b0}}, rsp_i[0].class_mask};

  assign result_o        = rsp_i[0].is_class ? class_result : regular_result;
  assign extension_bit_o = rsp_i[0].ext_bit;
  assign tag_o           = rsp_i[0].tag;  // Upper lane tags are copies

  // Collapse lane flags under the SIMD mask
  always_comb begin : collapse_status
    status_t acc;
    acc = '0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (lane_valid_i[i] && rsp_i[i].mask) begin
        acc = acc | rsp_i[i].status;
      end
    end
    status_o = acc;
  end

endmodule
